//--- filelist.f
+incdir+hw
hw/rvv_data_pkg.sv
hw/rvv_inst_pkg.sv
hw/rvv_decode.sv
hw/rvv_uop_queue.sv
hw/rvv_exec_retire.sv
hw/rvv_backend.sv
verification/rvv_clk_gen.sv
verification/rvv_backend_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build the testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary -Wno-fatal -f filelist.f --top-module rvv_backend_tb -o rvv_sim \
  || { echo "Build failed"; exit 1; }

out="$(./obj_dir/rvv_sim)"
echo "$out"
echo "$out" | grep -qx "Everything OK" && echo "Simulation passed" \
  || { echo "Simulation did not pass"; exit 1; }

//--- verification/rvv_backend_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "rvv_macros.svh"

module rvv_backend_tb;

  localparam logic [31:0] SEED = 32'h264a0fd5;
  // About 100 instructions of up to 8 micro-ops at about 4 cycles each
  localparam int TOTAL_INSTS = 100;
  localparam int CYCLE_LIMIT = TOTAL_INSTS * 8 * 4 + 800;
  localparam int DRAIN_LIMIT = 200;
  localparam int RDY_ALWAYS  = 0;
  localparam int RDY_RANDOM  = 1;
  localparam int RDY_STALL   = 2;

  typedef struct packed {
    rvv_data_pkg::vreg_idx_t idx;
    rvv_data_pkg::vreg_t     data;
    logic                    sat;
  } rec_t;

  logic                    clk;
  logic                    rst_n;
  logic                    inst_valid;
  rvv_inst_pkg::inst_t     inst;
  logic                    rt_ready;
  logic                    inst_ready;
  logic                    rt_valid;
  rvv_data_pkg::vreg_idx_t rt_index;
  rvv_data_pkg::vreg_t     rt_data;
  logic                    rt_vxsat;

  rvv_data_pkg::vreg_t model_rf [32];
  rec_t                exp_q [$];
  int                  rdy_mode = RDY_ALWAYS;
  logic [31:0]         stim_state = SEED;
  int                  cycle_count = 0;
  int                  retired = 0;
  int                  checks = 0;
  int                  errors = 0;
  int                  tests_failed = 0;
  int                  busy_run = 0;
  int                  bp_stalls = 0;

  rvv_clk_gen u_clk_gen (
    .clk   (clk),
    .rst_n (rst_n)
  );

  rvv_backend dut0 (
    .clk        (clk),
    .rst_n      (rst_n),
    .inst_valid (inst_valid),
    .inst       (inst),
    .rt_ready   (rt_ready),
    .inst_ready (inst_ready),
    .rt_valid   (rt_valid),
    .rt_index   (rt_index),
    .rt_data    (rt_data),
    .rt_vxsat   (rt_vxsat)
  );

  function automatic logic [31:0] lcg_step(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic rvv_inst_pkg::inst_t random_inst();
    stim_state = lcg_step(stim_state);
    // Instruction fields from the upper LCG bits
    return rvv_inst_pkg::inst_t'(stim_state[31:5]);
  endfunction

  function automatic rvv_inst_pkg::inst_t make_inst(input rvv_inst_pkg::rvv_op_e op,
                                                    input logic [4:0] vd,
                                                    input logic [4:0] vs1,
                                                    input logic [4:0] vs2,
                                                    input logic [1:0] lmul,
                                                    input logic [7:0] scalar);
    rvv_inst_pkg::inst_t i;
    i.op     = op;
    i.vd     = vd;
    i.vs1    = vs1;
    i.vs2    = vs2;
    i.lmul   = lmul;
    i.scalar = scalar;
    return i;
  endfunction

  // Reference model producing one record per register of the group
  function automatic void model_inst(input rvv_inst_pkg::inst_t i);
    int   vd;
    int   vs1;
    int   vs2;
    int   a;
    int   b;
    int   s;
    rec_t r;
    for (int k = 0; k < (1 << i.lmul); k++) begin
      vd     = (int'(i.vd) + k) % 32;
      vs1    = (int'(i.vs1) + k) % 32;
      vs2    = (int'(i.vs2) + k) % 32;
      r.idx  = vd[4:0];
      r.data = '0;
      r.sat  = 1'b0;
      for (int l = 0; l < `RVV_LANES; l++) begin
        a = int'(model_rf[vs1][l*`RVV_SEW +: `RVV_SEW]);
        b = int'(model_rf[vs2][l*`RVV_SEW +: `RVV_SEW]);
        case (i.op)
          rvv_inst_pkg::OP_VADD: s = (a + b) % 256;
          rvv_inst_pkg::OP_VSADDU: begin
            s = a + b;
            if (s > 255) begin
              s     = 255;
              r.sat = 1'b1;
            end
          end
          rvv_inst_pkg::OP_VSUB: s = (b - a + 256) % 256;
          default: s = int'(i.scalar);
        endcase
        r.data[l*`RVV_SEW +: `RVV_SEW] = s[7:0];
      end
      model_rf[vd] = r.data;
      exp_q.push_back(r);
    end
  endfunction

  // Starts just after an edge and returns just after the accepting edge
  task automatic send_inst(input rvv_inst_pkg::inst_t i);
    inst_valid = 1'b1;
    inst       = i;
    while (!inst_ready) begin
      @(posedge clk);
      #1;
    end
    model_inst(i);
    @(posedge clk);
    #1;
    inst_valid = 1'b0;
  endtask

  task automatic finish_test(input int num, input string name, input int errs_before);
    int idle;
    int last;
    idle = 0;
    last = retired;
    while (exp_q.size() != 0 && idle < DRAIN_LIMIT) begin
      @(posedge clk);
      #1;
      if (retired != last) begin
        idle = 0;
        last = retired;
      end else begin
        idle++;
      end
    end
    if (exp_q.size() != 0) begin
      $display("Retire port went quiet with %0d expected records never seen", exp_q.size());
      errors++;
      exp_q.delete();
    end
    if (errors == errs_before) begin
      $display("Test %0d %s: pass", num, name);
    end else begin
      tests_failed++;
      $display("Test %0d %s: FAIL with %0d errors", num, name, errors - errs_before);
    end
  endtask

  // Retire side back-pressure
  initial begin
    logic [31:0] st;
    int          stretch;
    st       = lcg_step(~SEED);
    stretch  = 0;
    rt_ready = 1'b0;
    forever begin
      @(posedge clk);
      #1;
      st = lcg_step(st);
      case (rdy_mode)
        RDY_RANDOM: rt_ready = (st[31:30] != 2'b00);
        RDY_STALL: begin
          if (stretch == 0) begin
            rt_ready = !rt_ready;
            // Long stalls with short bursts in between
            stretch = rt_ready ? 1 + int'(st[29:28]) : 12 + int'(st[28:24]);
          end else begin
            stretch--;
          end
        end
        default: rt_ready = 1'b1;
      endcase
    end
  end

  // Compare records mid-cycle where the outputs are settled
  always @(negedge clk) begin
    rec_t e;
    if (rst_n && inst_valid && !inst_ready) begin
      busy_run++;
    end else begin
      busy_run = 0;
    end
    // Busy past the longest expansion of 8 micro-ops means the queue is full
    if (busy_run > 8) begin
      bp_stalls++;
    end
    if (rst_n && rt_valid && rt_ready) begin
      retired++;
      if (exp_q.size() == 0) begin
        $display("Unexpected retire to v%0d with no record outstanding", rt_index);
        errors++;
      end else begin
        e = exp_q.pop_front();
        checks++;
        if (rt_index !== e.idx) begin
          $display("ERR rt_index: got %02h expected %02h", rt_index, e.idx);
          errors++;
        end
        if (rt_data !== e.data) begin
          $display("ERR rt_data: got %08h expected %08h (v%0d)", rt_data, e.data, e.idx);
          errors++;
        end
        if (rt_vxsat !== e.sat) begin
          $display("ERR rt_vxsat: got %0h expected %0h (v%0d)", rt_vxsat, e.sat, e.idx);
          errors++;
        end
      end
    end
  end

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
  end

  initial begin
    wait (cycle_count >= CYCLE_LIMIT);
    $display("Timeout after %0d cycles, %0d records pending", cycle_count, exp_q.size());
    $display("Something failed");
    $finish;
  end

  initial begin
    int errs;
    int stalls;
    inst_valid = 1'b0;
    inst       = '0;
    for (int r = 0; r < 32; r++) begin
      model_rf[r] = '0;
    end
    wait (rst_n);
    @(posedge clk);
    #1;

    errs = errors;
    send_inst(make_inst(rvv_inst_pkg::OP_VMVX, 5'd0, 5'd0, 5'd0, 2'd0, 8'h11));
    send_inst(make_inst(rvv_inst_pkg::OP_VMVX, 5'd1, 5'd0, 5'd0, 2'd1, 8'h22));
    send_inst(make_inst(rvv_inst_pkg::OP_VMVX, 5'd3, 5'd0, 5'd0, 2'd2, 8'h33));
    send_inst(make_inst(rvv_inst_pkg::OP_VMVX, 5'd8, 5'd0, 5'd0, 2'd3, 8'h44));
    finish_test(1, "move-scalar group sizes", errs);

    errs = errors;
    send_inst(make_inst(rvv_inst_pkg::OP_VMVX, 5'd16, 5'd0, 5'd0, 2'd0, 8'hf0));
    send_inst(make_inst(rvv_inst_pkg::OP_VMVX, 5'd17, 5'd0, 5'd0, 2'd0, 8'h25));
    send_inst(make_inst(rvv_inst_pkg::OP_VADD, 5'd18, 5'd16, 5'd17, 2'd0, 8'h00));
    send_inst(make_inst(rvv_inst_pkg::OP_VSUB, 5'd19, 5'd16, 5'd17, 2'd0, 8'h00));
    send_inst(make_inst(rvv_inst_pkg::OP_VSUB, 5'd20, 5'd17, 5'd16, 2'd1, 8'h00));
    finish_test(2, "wrapping add and subtract", errs);

    errs = errors;
    send_inst(make_inst(rvv_inst_pkg::OP_VMVX, 5'd21, 5'd0, 5'd0, 2'd0, 8'h90));
    send_inst(make_inst(rvv_inst_pkg::OP_VSADDU, 5'd22, 5'd21, 5'd21, 2'd0, 8'h00));
    send_inst(make_inst(rvv_inst_pkg::OP_VSADDU, 5'd23, 5'd21, 5'd0, 2'd0, 8'h00));
    send_inst(make_inst(rvv_inst_pkg::OP_VSADDU, 5'd12, 5'd8, 5'd21, 2'd1, 8'h00));
    finish_test(3, "saturating add", errs);

    errs = errors;
    send_inst(make_inst(rvv_inst_pkg::OP_VMVX, 5'd24, 5'd0, 5'd0, 2'd0, 8'h07));
    send_inst(make_inst(rvv_inst_pkg::OP_VADD, 5'd25, 5'd24, 5'd24, 2'd0, 8'h00));
    send_inst(make_inst(rvv_inst_pkg::OP_VSUB, 5'd26, 5'd24, 5'd25, 2'd0, 8'h00));
    send_inst(make_inst(rvv_inst_pkg::OP_VADD, 5'd24, 5'd26, 5'd25, 2'd0, 8'h00));
    send_inst(make_inst(rvv_inst_pkg::OP_VMVX, 5'd30, 5'd0, 5'd0, 2'd2, 8'h5a));
    send_inst(make_inst(rvv_inst_pkg::OP_VADD, 5'd29, 5'd30, 5'd31, 2'd2, 8'h00));
    finish_test(4, "dependent chain and v31 wrap", errs);

    errs     = errors;
    stalls   = bp_stalls;
    rdy_mode = RDY_STALL;
    for (int n = 0; n < 15; n++) begin
      send_inst(random_inst());
    end
    if (bp_stalls == stalls) begin
      $display("Instruction port never stalled while the retire port was held off");
      errors++;
    end
    finish_test(5, "long retire stalls", errs);

    errs     = errors;
    rdy_mode = RDY_RANDOM;
    for (int n = 0; n < 60; n++) begin
      send_inst(random_inst());
    end
    finish_test(6, "random instructions", errs);

    // Quiet tail where any extra retire shows up as unexpected
    rdy_mode = RDY_ALWAYS;
    repeat (20) @(posedge clk);
    $display("Tests 6, failed %0d, records checked %0d, errors %0d",
             tests_failed, checks, errors);
    if (errors == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- verification/rvv_clk_gen.sv
`timescale 1ns/1ps
`default_nettype none

module rvv_clk_gen (
  output logic clk,
  output logic rst_n
);

  initial begin
    clk = 1'b0;
    forever begin
      #5;
      clk = ~clk;
    end
  end

  // Three cycles of reset, released just after an edge
  initial begin
    rst_n = 1'b0;
    repeat (3) @(posedge clk);
    #1;
    rst_n = 1'b1;
  end

endmodule

`default_nettype wire

//--- hw/rvv_backend.sv
`timescale 1ns/1ps
`default_nettype none

module rvv_backend (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    inst_valid,
  input  rvv_inst_pkg::inst_t     inst,
  input  logic                    rt_ready,
  output logic                    inst_ready,
  output logic                    rt_valid,
  output rvv_data_pkg::vreg_idx_t rt_index,
  output rvv_data_pkg::vreg_t     rt_data,
  output logic                    rt_vxsat
);

  // Decoder to queue
  logic               uq_push;
  rvv_inst_pkg::uop_t uq_uop;
  logic               uq_full;

  // Queue to execute
  logic               uq_empty;
  rvv_inst_pkg::uop_t uq_head;
  logic               uq_pop;

  rvv_decode u_decode (
    .clk        (clk),
    .rst_n      (rst_n),
    .inst_valid (inst_valid),
    .inst       (inst),
    .uq_full    (uq_full),
    .inst_ready (inst_ready),
    .uq_push    (uq_push),
    .uq_uop     (uq_uop)
  );

  rvv_uop_queue u_uop_queue (
    .clk   (clk),
    .rst_n (rst_n),
    .push  (uq_push),
    .din   (uq_uop),
    .pop   (uq_pop),
    .dout  (uq_head),
    .full  (uq_full),
    .empty (uq_empty)
  );

  rvv_exec_retire u_exec (
    .clk      (clk),
    .rst_n    (rst_n),
    .uq_empty (uq_empty),
    .uq_head  (uq_head),
    .rt_ready (rt_ready),
    .uq_pop   (uq_pop),
    .rt_valid (rt_valid),
    .rt_index (rt_index),
    .rt_data  (rt_data),
    .rt_vxsat (rt_vxsat)
  );

endmodule

`default_nettype wire

//--- hw/rvv_exec_retire.sv
`timescale 1ns/1ps
`default_nettype none

`include "rvv_macros.svh"

module rvv_exec_retire (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      uq_empty,
  input  rvv_inst_pkg::uop_t        uq_head,
  input  logic                      rt_ready,
  output logic                      uq_pop,
  output logic                      rt_valid,
  output rvv_data_pkg::vreg_idx_t   rt_index,
  output rvv_data_pkg::vreg_t       rt_data,
  output logic                      rt_vxsat
);

  localparam int NUM_VREGS = 2 ** $bits(rvv_data_pkg::vreg_idx_t);

  rvv_data_pkg::vreg_t rf [NUM_VREGS];
  rvv_data_pkg::vreg_t src1;
  rvv_data_pkg::vreg_t src2;
  rvv_data_pkg::vreg_t result;
  logic                sat;

  assign src1 = rf[uq_head.vs1];
  assign src2 = rf[uq_head.vs2];

  // Retire register free, or draining on this edge
  assign uq_pop = !uq_empty && (!rt_valid || rt_ready);

  // Lane-wise datapath
  always_comb begin
    rvv_data_pkg::elem_t a;
    rvv_data_pkg::elem_t b;
    logic [`RVV_SEW:0]   wide;
    result = '0;
    sat    = 1'b0;
    for (int l = 0; l < `RVV_LANES; l++) begin
      a    = src1[l*`RVV_SEW +: `RVV_SEW];
      b    = src2[l*`RVV_SEW +: `RVV_SEW];
      wide = {1'b0, b} + {1'b0, a};
      case (uq_head.op)
        rvv_inst_pkg::OP_VADD: begin
          result[l*`RVV_SEW +: `RVV_SEW] = wide[`RVV_SEW-1:0];
        end
        rvv_inst_pkg::OP_VSADDU: begin
          // Carry out means the lane clamps to all ones
          if (wide[`RVV_SEW]) begin
            result[l*`RVV_SEW +: `RVV_SEW] = '1;
            sat = 1'b1;
          end else begin
            result[l*`RVV_SEW +: `RVV_SEW] = wide[`RVV_SEW-1:0];
          end
        end
        rvv_inst_pkg::OP_VSUB: begin
          // vs2 - vs1
          result[l*`RVV_SEW +: `RVV_SEW] = b - a;
        end
        rvv_inst_pkg::OP_VMVX: begin
          result[l*`RVV_SEW +: `RVV_SEW] = uq_head.scalar;
        end
        default: begin
          result[l*`RVV_SEW +: `RVV_SEW] = '0;
        end
      endcase
    end
  end

  // Write-back at pop time so the next micro-op sees it
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int r = 0; r < NUM_VREGS; r++) begin
        rf[r] <= '0;
      end
    end else if (uq_pop) begin
      rf[uq_head.vd] <= result;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rt_valid <= 1'b0;
    end else if (uq_pop) begin
      rt_valid <= 1'b1;
    end else if (rt_ready) begin
      rt_valid <= 1'b0;
    end
  end

  // Retire record payload
  always_ff @(posedge clk) begin
    if (uq_pop) begin
      rt_index <= uq_head.vd;
      rt_data  <= result;
      rt_vxsat <= sat;
    end
  end

endmodule

`default_nettype wire

//--- hw/rvv_uop_queue.sv
`timescale 1ns/1ps
`default_nettype none

`include "rvv_macros.svh"

module rvv_uop_queue (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               push,
  input  rvv_inst_pkg::uop_t din,
  input  logic               pop,
  output rvv_inst_pkg::uop_t dout,
  output logic               full,
  output logic               empty
);

  localparam int PTR_W = $clog2(`RVV_UQ_DEPTH);
  localparam int CNT_W = $clog2(`RVV_UQ_DEPTH + 1);

  rvv_inst_pkg::uop_t mem [`RVV_UQ_DEPTH];
  logic [PTR_W-1:0]   wr_ptr;
  logic [PTR_W-1:0]   rd_ptr;
  logic [CNT_W-1:0]   count;
  logic               do_push;
  logic               do_pop;

  // Step a pointer around the ring
  function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
    if (ptr == PTR_W'(`RVV_UQ_DEPTH - 1)) begin
      next_ptr = '0;
    end else begin
      next_ptr = ptr + PTR_W'(1);
    end
  endfunction

  assign full    = (count == CNT_W'(`RVV_UQ_DEPTH));
  assign empty   = (count == '0);
  assign do_push = push && !full;
  assign do_pop  = pop && !empty;
  assign dout    = mem[rd_ptr];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= next_ptr(wr_ptr);
      end
      if (do_pop) begin
        rd_ptr <= next_ptr(rd_ptr);
      end
      // Simultaneous push and pop keeps the count
      if (do_push && !do_pop) begin
        count <= count + CNT_W'(1);
      end else if (do_pop && !do_push) begin
        count <= count - CNT_W'(1);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (do_push) begin
      mem[wr_ptr] <= din;
    end
  end

endmodule

`default_nettype wire

//--- hw/rvv_decode.sv
`timescale 1ns/1ps
`default_nettype none

module rvv_decode (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                inst_valid,
  input  rvv_inst_pkg::inst_t inst,
  input  logic                uq_full,
  output logic                inst_ready,
  output logic                uq_push,
  output rvv_inst_pkg::uop_t  uq_uop
);

  typedef enum logic {
    DEC_IDLE,
    DEC_EXPAND
  } dec_state_e;

  dec_state_e          state;
  rvv_inst_pkg::inst_t inst_q;
  // Up to 8 micro-ops remain, so 4 bits
  logic [3:0]          uops_left;
  logic [2:0]          offset;

  // Register number within the group, wraps past v31
  function automatic rvv_data_pkg::vreg_idx_t grp_reg(input rvv_data_pkg::vreg_idx_t base,
                                                      input logic [2:0] ofs);
    grp_reg = base + rvv_data_pkg::vreg_idx_t'(ofs);
  endfunction

  assign inst_ready = (state == DEC_IDLE);
  assign uq_push    = (state == DEC_EXPAND) && !uq_full;

  always_comb begin
    uq_uop.op     = inst_q.op;
    uq_uop.vd     = grp_reg(inst_q.vd, offset);
    uq_uop.vs1    = grp_reg(inst_q.vs1, offset);
    uq_uop.vs2    = grp_reg(inst_q.vs2, offset);
    uq_uop.scalar = inst_q.scalar;
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state     <= DEC_IDLE;
      uops_left <= '0;
      offset    <= '0;
    end else begin
      case (state)
        DEC_IDLE: begin
          if (inst_valid) begin
            state     <= DEC_EXPAND;
            uops_left <= 4'd1 << inst.lmul;
            offset    <= '0;
          end
        end
        DEC_EXPAND: begin
          // Advance only when the queue took the micro-op
          if (uq_push) begin
            if (uops_left == 4'd1) begin
              state <= DEC_IDLE;
            end
            uops_left <= uops_left - 4'd1;
            offset    <= offset + 3'd1;
          end
        end
        default: state <= DEC_IDLE;
      endcase
    end
  end

  // Instruction payload, loaded on acceptance
  always_ff @(posedge clk) begin
    if (inst_valid && inst_ready) begin
      inst_q <= inst;
    end
  end

endmodule

`default_nettype wire

//--- hw/rvv_inst_pkg.sv
`default_nettype none

package rvv_inst_pkg;

  // Supported lane operations
  typedef enum logic [1:0] {
    OP_VADD   = 2'd0,
    OP_VSADDU = 2'd1,
    OP_VSUB   = 2'd2,
    OP_VMVX   = 2'd3
  } rvv_op_e;

  // Group size code, 0..3 -> 1, 2, 4, 8 registers
  typedef logic [1:0] lmul_t;

  // Instruction as it arrives on the input port
  typedef struct packed {
    rvv_op_e                 op;
    rvv_data_pkg::vreg_idx_t vd;
    rvv_data_pkg::vreg_idx_t vs1;
    rvv_data_pkg::vreg_idx_t vs2;
    lmul_t                   lmul;
    rvv_data_pkg::elem_t     scalar;
  } inst_t;

  // One register-sized slice of an instruction
  typedef struct packed {
    rvv_op_e                 op;
    rvv_data_pkg::vreg_idx_t vd;
    rvv_data_pkg::vreg_idx_t vs1;
    rvv_data_pkg::vreg_idx_t vs2;
    rvv_data_pkg::elem_t     scalar;
  } uop_t;

endpackage

`default_nettype wire

//--- hw/rvv_data_pkg.sv
`default_nettype none

`include "rvv_macros.svh"

package rvv_data_pkg;

  // Architectural vector register number, v0 to v31
  typedef logic [4:0] vreg_idx_t;

  // Single lane element
  typedef logic [`RVV_SEW-1:0] elem_t;

  // Full register word, lane 0 in the low bits
  typedef logic [`RVV_VLEN-1:0] vreg_t;

endpackage

`default_nettype wire

//--- hw/rvv_macros.svh
`ifndef RVV_MACROS_SVH
`define RVV_MACROS_SVH

// Bits in one vector register
`define RVV_VLEN 32

// Bits in one element
`define RVV_SEW 8

// Elements per register, VLEN / SEW
`define RVV_LANES 4

// Micro-op queue entries
`define RVV_UQ_DEPTH 4

`endif
